// ==== design/clock_config.svh ====
// digital clock tick rates, field limits and display constants
`ifndef CLOCK_CONFIG_SVH
`define CLOCK_CONFIG_SVH

// ------------------------------------------------------------
// tick rates, in clk cycles
// ------------------------------------------------------------
`define CLK_PER_SEC	64	// kept small for simulation
`define CLK_PER_SCAN	4	// one digit step
`define SCANS_PER_BLINK	12	// half blink period, in scan steps
`define CLK_PER_SAMPLE	8	// button sample rate

// ------------------------------------------------------------
// display and time field limits
// ------------------------------------------------------------
`define NUM_DIGITS	6
`define SEC_MAX		59
`define MIN_MAX		59
`define HOUR_MAX	23

`endif

// ==== design/clock_pkg.sv ====
// digital clock types and digit helper functions
package clock_pkg;

	// user mode, code 2'b11 unused
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'b00,
		MODE_SETUP = 2'b01,
		MODE_ALARM = 2'b10
	} mode_t;

	// selected field, also picks the digit pair on the display
	typedef enum logic [1:0] {
		POS_SEC  = 2'b00,
		POS_MIN  = 2'b01,
		POS_HOUR = 2'b10
	} pos_t;

	typedef struct packed {
		logic [5:0] hour;
		logic [5:0] min;
		logic [5:0] sec;
	} hms_t;

	typedef logic [6:0] seg_t;	// {a, b, c, d, e, f, g}

	function automatic seg_t seg_encode(input logic [3:0] digit);
		case (digit)
			4'd0:    return 7'b111_1110;
			4'd1:    return 7'b011_0000;
			4'd2:    return 7'b110_1101;
			4'd3:    return 7'b111_1001;
			4'd4:    return 7'b011_0011;
			4'd5:    return 7'b101_1011;
			4'd6:    return 7'b101_1111;
			4'd7:    return 7'b111_0000;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b111_0011;
			default: return 7'b000_0000;	// blank
		endcase
	endfunction

	// split 0..59 into decimal digits
	function automatic logic [3:0] tens_of(input logic [5:0] value);
		return 4'(value / 6'd10);
	endfunction

	function automatic logic [3:0] ones_of(input logic [5:0] value);
		return 4'(value % 6'd10);
	endfunction

endpackage

// ==== design/clock_ctrl_if.sv ====
// user control state from the button controller to timekeeper and display
`timescale 1ns/1ps

interface clock_ctrl_if;

	clock_pkg::mode_t mode;
	clock_pkg::pos_t  pos;
	logic             inc;		// one cycle per increment press
	logic             alarm_en;

	modport ctrl (
		output mode, pos, inc, alarm_en
	);

	modport keep (
		input mode, inc, alarm_en
	);

	modport show (
		input mode, pos
	);

endinterface

// ==== design/tick_gen.sv ====
// prescaler giving one-cycle second, scan and button-sample enables
`timescale 1ns/1ps
`include "clock_config.svh"

module tick_gen (
	input  logic clk,
	input  logic rst_n,
	output logic o_sec_tick,
	output logic o_scan_tick,
	output logic o_sample_tick
);

	localparam int unsigned PERIOD [3] = '{`CLK_PER_SEC, `CLK_PER_SCAN, `CLK_PER_SAMPLE};

	logic [2:0] ticks;

	// one free-running divider per enable, pulse on the wrap
	for (genvar g = 0; g < 3; g++) begin : g_div
		localparam int unsigned P = PERIOD[g];
		localparam int W = (P > 1) ? $clog2(P) : 1;

		logic [W-1:0] cnt;
		logic         tick;

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				cnt  <= '0;
				tick <= 1'b0;
			end else if (cnt == W'(P - 1)) begin
				cnt  <= '0;
				tick <= 1'b1;	// first pulse on cycle P
			end else begin
				cnt  <= cnt + 1'b1;
				tick <= 1'b0;
			end
		end

		assign ticks[g] = tick;
	end

	assign o_sec_tick    = ticks[0];
	assign o_scan_tick   = ticks[1];
	assign o_sample_tick = ticks[2];

endmodule

// ==== design/button_ctrl.sv ====
// button sampling, press detection and the mode, position and alarm-enable state
`timescale 1ns/1ps

module button_ctrl (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       i_sample_tick,
	input  logic       i_btn_mode,
	input  logic       i_btn_pos,
	input  logic       i_btn_inc,
	input  logic       i_btn_alarm,
	clock_ctrl_if.ctrl ctrl_if
);

	localparam int B_MODE  = 0;
	localparam int B_POS   = 1;
	localparam int B_INC   = 2;
	localparam int B_ALARM = 3;

	logic [3:0] btn;
	logic [3:0] smp1;
	logic [3:0] smp2;
	logic [3:0] smp2_q;
	logic [3:0] press;

	assign btn = {i_btn_alarm, i_btn_inc, i_btn_pos, i_btn_mode};

	// ------------------------------------------------------------
	// two-stage sampling at the slow rate filters bounce
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			smp1   <= '0;
			smp2   <= '0;
			smp2_q <= '0;
		end else begin
			if (i_sample_tick) begin
				smp1 <= btn;
				smp2 <= smp1;
			end
			smp2_q <= smp2;
		end
	end

	assign press = smp2 & ~smp2_q;	// rise of second stage, one cycle

	// ------------------------------------------------------------
	// control registers
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_if.mode     <= clock_pkg::MODE_CLOCK;
			ctrl_if.pos      <= clock_pkg::POS_SEC;
			ctrl_if.alarm_en <= 1'b0;
			ctrl_if.inc      <= 1'b0;
		end else begin
			if (press[B_MODE]) begin
				case (ctrl_if.mode)
					clock_pkg::MODE_CLOCK: ctrl_if.mode <= clock_pkg::MODE_SETUP;
					clock_pkg::MODE_SETUP: ctrl_if.mode <= clock_pkg::MODE_ALARM;
					default:               ctrl_if.mode <= clock_pkg::MODE_CLOCK;
				endcase
			end
			if (press[B_POS]) begin
				case (ctrl_if.pos)
					clock_pkg::POS_SEC: ctrl_if.pos <= clock_pkg::POS_MIN;
					clock_pkg::POS_MIN: ctrl_if.pos <= clock_pkg::POS_HOUR;
					default:            ctrl_if.pos <= clock_pkg::POS_SEC;
				endcase
			end
			if (press[B_ALARM])
				ctrl_if.alarm_en <= ~ctrl_if.alarm_en;
			// increment only means something while editing
			ctrl_if.inc <= press[B_INC] && (ctrl_if.mode != clock_pkg::MODE_CLOCK);
		end
	end

endmodule

// ==== design/hms_counter.sv ====
// hour:minute:second register bank with running tick and single-field increment
`timescale 1ns/1ps
`include "clock_config.svh"

module hms_counter (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             i_run_tick,
	input  logic             i_inc,
	input  clock_pkg::pos_t  i_pos,
	output clock_pkg::hms_t  o_time
);

	localparam logic [5:0] SEC_LIM  = 6'(`SEC_MAX);
	localparam logic [5:0] MIN_LIM  = 6'(`MIN_MAX);
	localparam logic [5:0] HOUR_LIM = 6'(`HOUR_MAX);

	logic sec_wrap;
	logic min_wrap;
	logic hour_wrap;

	assign sec_wrap  = (o_time.sec == SEC_LIM);
	assign min_wrap  = (o_time.min == MIN_LIM);
	assign hour_wrap = (o_time.hour == HOUR_LIM);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_time <= '0;
		end else if (i_run_tick) begin
			// ripple carry sec -> min -> hour
			o_time.sec <= sec_wrap ? 6'd0 : o_time.sec + 6'd1;
			if (sec_wrap) begin
				o_time.min <= min_wrap ? 6'd0 : o_time.min + 6'd1;
				if (min_wrap)
					o_time.hour <= hour_wrap ? 6'd0 : o_time.hour + 6'd1;
			end
		end else if (i_inc) begin
			case (i_pos)	// no carry when setting
				clock_pkg::POS_SEC:  o_time.sec  <= sec_wrap  ? 6'd0 : o_time.sec + 6'd1;
				clock_pkg::POS_MIN:  o_time.min  <= min_wrap  ? 6'd0 : o_time.min + 6'd1;
				clock_pkg::POS_HOUR: o_time.hour <= hour_wrap ? 6'd0 : o_time.hour + 6'd1;
				default:             o_time      <= o_time;
			endcase
		end
	end

endmodule

// ==== design/timekeeper.sv ====
// clock and alarm time banks, shown-time select and alarm match flag
`timescale 1ns/1ps

module timekeeper (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             i_sec_tick,
	clock_ctrl_if.keep       ctrl_if,
	input  clock_pkg::pos_t  i_pos,
	output clock_pkg::hms_t  o_shown,
	output logic             o_alarm
);

	clock_pkg::hms_t clock_time;
	clock_pkg::hms_t alarm_time;
	logic            in_setup;
	logic            in_alarm;

	assign in_setup = (ctrl_if.mode == clock_pkg::MODE_SETUP);
	assign in_alarm = (ctrl_if.mode == clock_pkg::MODE_ALARM);

	hms_counter u_clock_cnt (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_run_tick (i_sec_tick && !in_setup),	// stopped while setting
		.i_inc      (ctrl_if.inc && in_setup),
		.i_pos      (i_pos),
		.o_time     (clock_time)
	);

	hms_counter u_alarm_cnt (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_run_tick (1'b0),	// alarm time never runs
		.i_inc      (ctrl_if.inc && in_alarm),
		.i_pos      (i_pos),
		.o_time     (alarm_time)
	);

	assign o_shown = in_alarm ? alarm_time : clock_time;

	// match flag sticks until the alarm is disabled
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_alarm <= 1'b0;
		else if (!ctrl_if.alarm_en)
			o_alarm <= 1'b0;
		else if (clock_time == alarm_time)
			o_alarm <= 1'b1;
	end

endmodule

// ==== design/display_scan.sv ====
// multiplexed seven-segment scan with blink masking and decimal point
`timescale 1ns/1ps
`include "clock_config.svh"

module display_scan (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   i_scan_tick,
	input  clock_pkg::hms_t        i_shown,
	clock_ctrl_if.show             ctrl_if,
	output clock_pkg::seg_t        o_seg,
	output logic                   o_seg_dp,
	output logic [`NUM_DIGITS-1:0] o_seg_enb
);

	localparam int IDX_W   = $clog2(`NUM_DIGITS);
	localparam int BLINK_W = $clog2(`SCANS_PER_BLINK);

	logic [IDX_W-1:0]   idx;
	logic [BLINK_W-1:0] blink_cnt;
	logic               blink_dark;
	logic [3:0]         digit;
	logic               editing;
	logic               on_field;

	// ------------------------------------------------------------
	// digit index and blink phase
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx        <= '0;
			blink_cnt  <= '0;
			blink_dark <= 1'b0;	// start lit
		end else if (i_scan_tick) begin
			idx <= (idx == IDX_W'(`NUM_DIGITS - 1)) ? '0 : idx + 1'b1;
			if (blink_cnt == BLINK_W'(`SCANS_PER_BLINK - 1)) begin
				blink_cnt  <= '0;
				blink_dark <= ~blink_dark;
			end else begin
				blink_cnt <= blink_cnt + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------
	// digit select, index 0 is seconds ones
	// ------------------------------------------------------------
	always_comb begin
		case (idx)
			3'd0:    digit = clock_pkg::ones_of(i_shown.sec);
			3'd1:    digit = clock_pkg::tens_of(i_shown.sec);
			3'd2:    digit = clock_pkg::ones_of(i_shown.min);
			3'd3:    digit = clock_pkg::tens_of(i_shown.min);
			3'd4:    digit = clock_pkg::ones_of(i_shown.hour);
			3'd5:    digit = clock_pkg::tens_of(i_shown.hour);
			default: digit = 4'hf;	// blank
		endcase
	end

	assign editing  = (ctrl_if.mode == clock_pkg::MODE_SETUP) ||
	                  (ctrl_if.mode == clock_pkg::MODE_ALARM);
	assign on_field = (idx[IDX_W-1:1] == ctrl_if.pos);	// digit pair of the field

	assign o_seg = clock_pkg::seg_encode(digit);

	// active low, all off while the selected pair blinks dark
	assign o_seg_enb = (editing && blink_dark && on_field) ? '1 :
	                   ~(`NUM_DIGITS'(1) << idx);

	assign o_seg_dp = editing && (idx == {ctrl_if.pos, 1'b0});

endmodule

// ==== design/clock_top.sv ====
// six-digit seven-segment digital clock top level
`timescale 1ns/1ps
`include "clock_config.svh"

module clock_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   i_btn_mode,
	input  logic                   i_btn_pos,
	input  logic                   i_btn_inc,
	input  logic                   i_btn_alarm,
	output clock_pkg::seg_t        o_seg,
	output logic                   o_seg_dp,
	output logic [`NUM_DIGITS-1:0] o_seg_enb,
	output logic                   o_alarm
);

	logic            sec_tick;
	logic            scan_tick;
	logic            sample_tick;
	clock_pkg::hms_t shown;

	clock_ctrl_if u_ctrl_if ();

	tick_gen u_tick_gen (
		.clk           (clk),
		.rst_n         (rst_n),
		.o_sec_tick    (sec_tick),
		.o_scan_tick   (scan_tick),
		.o_sample_tick (sample_tick)
	);

	button_ctrl u_button_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_sample_tick (sample_tick),
		.i_btn_mode    (i_btn_mode),
		.i_btn_pos     (i_btn_pos),
		.i_btn_inc     (i_btn_inc),
		.i_btn_alarm   (i_btn_alarm),
		.ctrl_if       (u_ctrl_if.ctrl)
	);

	timekeeper u_timekeeper (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_sec_tick (sec_tick),
		.ctrl_if    (u_ctrl_if.keep),
		.i_pos      (u_ctrl_if.pos),	// field select for both banks
		.o_shown    (shown),
		.o_alarm    (o_alarm)
	);

	display_scan u_display_scan (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_scan_tick (scan_tick),
		.i_shown     (shown),
		.ctrl_if     (u_ctrl_if.show),
		.o_seg       (o_seg),
		.o_seg_dp    (o_seg_dp),
		.o_seg_enb   (o_seg_enb)
	);

endmodule

// ==== verif/clock_checker.sv ====
// display watcher that rebuilds the shown time and checks the scan outputs
`timescale 1ns/1ps
`include "clock_config.svh"

module clock_checker (
	input  logic                   clk,
	input  clock_pkg::seg_t        i_seg,
	input  logic                   i_seg_dp,
	input  logic [`NUM_DIGITS-1:0] i_seg_enb,
	input  logic                   i_alarm,
	input  logic                   i_req,
	input  logic [1:0]             i_kind,		// 0 time, 1 edit display, 2 reset state
	input  clock_pkg::hms_t        i_exp,
	input  clock_pkg::pos_t        i_pos,
	input  logic [8*16-1:0]        i_name,
	output logic                   o_done,
	output int                     o_errors
);

	int errs;

	assign o_errors = errs;

	// reverse lookup in the segment table
	function automatic int decode(input clock_pkg::seg_t s);
		for (int d = 0; d < 10; d++)
			if (clock_pkg::seg_encode(4'(d)) == s)
				return d;
		return 15;
	endfunction

	task automatic compare_time();
		int                     d [`NUM_DIGITS];
		logic [`NUM_DIGITS-1:0] seen;
		int                     t;
		clock_pkg::hms_t        got;
		seen = '0;
		t    = 0;
		while (seen != '1 && t < 200) begin
			for (int i = 0; i < `NUM_DIGITS; i++) begin
				if (!i_seg_enb[i]) begin
					d[i]    = decode(i_seg);
					seen[i] = 1'b1;
				end
			end
			if (seen != '1) begin
				@(posedge clk);
				t++;
			end
		end
		if (seen != '1) begin
			$display("%0s: no full unmasked scan seen", i_name);
			errs++;
		end else begin
			got.sec  = 6'(d[1] * 10 + d[0]);
			got.min  = 6'(d[3] * 10 + d[2]);
			got.hour = 6'(d[5] * 10 + d[4]);
			if (got != i_exp) begin
				$display("FAIL %0s expected %02d:%02d:%02d actual %02d:%02d:%02d", i_name,
				         i_exp.hour, i_exp.min, i_exp.sec, got.hour, got.min, got.sec);
				errs++;
			end
		end
	endtask

	task automatic watch_edit();
		int   lo;
		logic dark;
		logic lit;
		logic dp_seen;
		logic dp_bad;
		lo      = 2 * int'(i_pos);	// low digit of the field
		dark    = 1'b0;
		lit     = 1'b0;
		dp_seen = 1'b0;
		dp_bad  = 1'b0;
		for (int t = 0; t < 400; t++) begin
			if (i_seg_enb == '1)
				dark = 1'b1;
			if (!i_seg_enb[lo] || !i_seg_enb[lo+1])
				lit = 1'b1;
			if (i_seg_dp) begin
				dp_seen = 1'b1;
				if (i_seg_enb != '1 && i_seg_enb[lo])
					dp_bad = 1'b1;
			end
			@(posedge clk);
		end
		if (!dark || !lit) begin
			$display("%0s: selected field did not blink", i_name);
			errs++;
		end
		if (!dp_seen || dp_bad) begin
			$display("%0s: decimal point not only on digit %0d", i_name, lo);
			errs++;
		end
	endtask

	task automatic check_idle();
		if (i_seg_enb != `NUM_DIGITS'(6'b111110)) begin
			$display("FAIL %0s expected %b actual %b", i_name, 6'b111110, i_seg_enb);
			errs++;
		end
		if (i_seg_dp || i_alarm) begin
			$display("FAIL %0s expected dp 0 alarm 0 actual dp %0b alarm %0b",
			         i_name, i_seg_dp, i_alarm);
			errs++;
		end
	endtask

	initial begin
		o_done = 1'b0;
		errs   = 0;
		forever begin
			@(posedge clk);
			if (i_req) begin
				o_done <= 1'b0;
				case (i_kind)
					2'd0:    compare_time();
					2'd1:    watch_edit();
					default: check_idle();
				endcase
				o_done <= 1'b1;
			end
		end
	end

endmodule

// ==== verif/clock_sva.sv ====
// concurrent assertions on the digital clock top-level outputs
`timescale 1ns/1ps
`include "clock_config.svh"

module clock_sva (
	input logic                   clk,
	input logic                   rst_n,
	input logic [`NUM_DIGITS-1:0] o_seg_enb,
	input logic                   o_seg_dp,
	input logic                   o_alarm,
	input clock_pkg::mode_t       i_mode
);

	// at most one digit driven at a time
	a_one_digit: assert property (@(posedge clk) disable iff (!rst_n)
		$countones(~o_seg_enb) <= 1)
		else $error("more than one digit enable low: %b", o_seg_enb);

	a_alarm_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> !o_alarm)
		else $error("o_alarm high right after reset release");

	// no decimal point outside the editing modes
	a_dp_in_clock: assert property (@(posedge clk) disable iff (!rst_n)
		(i_mode == clock_pkg::MODE_CLOCK) |-> !o_seg_dp)
		else $error("decimal point lit in clock mode");

endmodule

bind clock_top clock_sva u_sva (
	.clk       (clk),
	.rst_n     (rst_n),
	.o_seg_enb (o_seg_enb),
	.o_seg_dp  (o_seg_dp),
	.o_alarm   (o_alarm),
	.i_mode    (u_ctrl_if.mode)
);

// ==== verif/tb_clock.sv ====
// testbench top for the six-digit seven-segment digital clock
`timescale 1ns/1ps
`include "clock_config.svh"

module tb_clock;

	localparam int unsigned SECS_PER_MIN  = `SEC_MAX + 1;
	localparam int unsigned SECS_PER_HOUR = SECS_PER_MIN * (`MIN_MAX + 1);
	localparam int unsigned SECS_PER_DAY  = SECS_PER_HOUR * (`HOUR_MAX + 1);

	logic                   clk;
	logic                   rst_n;
	logic                   btn_mode;
	logic                   btn_pos;
	logic                   btn_inc;
	logic                   btn_alarm;
	clock_pkg::seg_t        seg;
	logic                   seg_dp;
	logic [`NUM_DIGITS-1:0] seg_enb;
	logic                   alarm;

	logic                   chk_req;
	logic [1:0]             chk_kind;
	clock_pkg::hms_t        chk_exp;
	clock_pkg::pos_t        chk_pos;
	logic [8*16-1:0]        chk_name;
	logic                   chk_done;
	int                     chk_errors;

	int unsigned            cyc;		// cycles since reset release
	int unsigned            ref_secs;	// running seconds seen by the model
	int unsigned            secs_used;
	clock_pkg::hms_t        ref_base;
	clock_pkg::hms_t        alarm_ref;
	clock_pkg::mode_t       model_mode;
	int                     tb_errors;
	int                     timeouts;
	int                     n_inc;

	always #20 clk = ~clk;

	clock_top i_clock_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_btn_mode  (btn_mode),
		.i_btn_pos   (btn_pos),
		.i_btn_inc   (btn_inc),
		.i_btn_alarm (btn_alarm),
		.o_seg       (seg),
		.o_seg_dp    (seg_dp),
		.o_seg_enb   (seg_enb),
		.o_alarm     (alarm)
	);

	clock_checker u_checker (
		.clk       (clk),
		.i_seg     (seg),
		.i_seg_dp  (seg_dp),
		.i_seg_enb (seg_enb),
		.i_alarm   (alarm),
		.i_req     (chk_req),
		.i_kind    (chk_kind),
		.i_exp     (chk_exp),
		.i_pos     (chk_pos),
		.i_name    (chk_name),
		.o_done    (chk_done),
		.o_errors  (chk_errors)
	);

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------
	function automatic clock_pkg::hms_t expected_time(input clock_pkg::hms_t base,
	                                                  input int unsigned secs);
		int unsigned     total;
		clock_pkg::hms_t t;
		total  = base.hour * SECS_PER_HOUR + base.min * SECS_PER_MIN + base.sec + secs;
		total  = total % SECS_PER_DAY;	// 23:59:59 rolls to midnight
		t.hour = 6'(total / SECS_PER_HOUR);
		t.min  = 6'((total / SECS_PER_MIN) % (`MIN_MAX + 1));
		t.sec  = 6'(total % SECS_PER_MIN);
		return t;
	endfunction

	// setting a field wraps it with no carry
	function automatic clock_pkg::hms_t field_inc(input clock_pkg::hms_t t,
	                                              input clock_pkg::pos_t pos, input int n);
		case (pos)
			clock_pkg::POS_SEC:  t.sec  = 6'((t.sec + n) % (`SEC_MAX + 1));
			clock_pkg::POS_MIN:  t.min  = 6'((t.min + n) % (`MIN_MAX + 1));
			default:             t.hour = 6'((t.hour + n) % (`HOUR_MAX + 1));
		endcase
		return t;
	endfunction

	function automatic clock_pkg::hms_t now_expected();
		return expected_time(ref_base, ref_secs - secs_used);
	endfunction

	// seconds tick on every CLK_PER_SEC cycle, frozen in setup
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cyc      <= 0;
			ref_secs <= 0;
		end else begin
			cyc <= cyc + 1;
			if ((cyc + 1) % `CLK_PER_SEC == 0 && model_mode != clock_pkg::MODE_SETUP)
				ref_secs <= ref_secs + 1;
		end
	end

	// ------------------------------------------------------------
	// stimulus helpers
	// ------------------------------------------------------------
	task automatic wait_phase(input int unsigned ph);
		int t;
		t = 0;
		while (cyc % `CLK_PER_SEC != ph && timeouts == 0) begin
			@(posedge clk);
			t++;
			if (t > 4 * `CLK_PER_SEC) begin
				$display("timeout: second phase %0d never reached", ph);
				timeouts++;
			end
		end
	endtask

	// starts just after a second tick so the press lands before the next one
	task automatic press(input int which);
		wait_phase(8);
		case (which)
			0: begin
				btn_mode <= 1'b1;
				case (model_mode)
					clock_pkg::MODE_CLOCK: model_mode = clock_pkg::MODE_SETUP;
					clock_pkg::MODE_SETUP: model_mode = clock_pkg::MODE_ALARM;
					default:               model_mode = clock_pkg::MODE_CLOCK;
				endcase
			end
			1:       btn_pos   <= 1'b1;
			2:       btn_inc   <= 1'b1;
			default: btn_alarm <= 1'b1;
		endcase
		repeat (3 * `CLK_PER_SAMPLE) @(posedge clk);
		{btn_alarm, btn_inc, btn_pos, btn_mode} <= '0;
		repeat (3 * `CLK_PER_SAMPLE) @(posedge clk);
	endtask

	task automatic run_check(input logic [1:0] kind, input clock_pkg::hms_t exp,
	                         input clock_pkg::pos_t pos, input logic [8*16-1:0] name);
		int t;
		t = 0;
		chk_kind <= kind;
		chk_exp  <= exp;
		chk_pos  <= pos;
		chk_name <= name;
		chk_req  <= 1'b1;
		@(posedge clk);
		chk_req <= 1'b0;
		@(posedge clk);
		while (!chk_done && timeouts == 0) begin
			@(posedge clk);
			t++;
			if (t > 1000) begin
				$display("timeout: checker gave no answer for %0s", name);
				timeouts++;
			end
		end
	endtask

	task automatic wait_alarm(input logic level, input int limit);
		int t;
		t = 0;
		while (alarm != level && timeouts == 0) begin
			@(posedge clk);
			t++;
			if (t > limit) begin
				$display("timeout: o_alarm never went to %0b", level);
				timeouts++;
			end
		end
	endtask

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------
	initial begin
		clock_pkg::hms_t now_t;
		clk        = 1'b0;
		rst_n      = 1'b0;
		btn_mode   = 1'b0;
		btn_pos    = 1'b0;
		btn_inc    = 1'b0;
		btn_alarm  = 1'b0;
		chk_req    = 1'b0;
		chk_kind   = 2'd0;
		chk_exp    = '0;
		chk_pos    = clock_pkg::POS_SEC;
		chk_name   = '0;
		ref_base   = '0;
		alarm_ref  = '0;
		secs_used  = 0;
		model_mode = clock_pkg::MODE_CLOCK;
		tb_errors  = 0;
		timeouts   = 0;
		void'($urandom(32'h8d3e_e368));

		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		run_check(2'd2, '0, clock_pkg::POS_SEC, "reset_state");
		run_check(2'd0, '0, clock_pkg::POS_SEC, "reset_time");

		// running time with a seconds to minutes carry
		wait_phase(4);
		while (ref_secs < 62 && timeouts == 0) begin
			@(posedge clk);
			wait_phase(4);
		end
		run_check(2'd0, now_expected(), clock_pkg::POS_SEC, "running");

		// setup on the minutes field
		press(0);
		press(1);
		n_inc = 1 + int'($urandom % 5);
		repeat (n_inc) press(2);
		ref_base  = field_inc(now_expected(), clock_pkg::POS_MIN, n_inc);
		secs_used = ref_secs;
		wait_phase(4);
		run_check(2'd0, now_expected(), clock_pkg::POS_MIN, "setup_min");
		run_check(2'd1, '0, clock_pkg::POS_MIN, "setup_blink");

		// hour wrap through 23
		press(1);
		n_inc = 24 + int'($urandom % 3);
		repeat (n_inc) press(2);
		ref_base  = field_inc(now_expected(), clock_pkg::POS_HOUR, n_inc);
		secs_used = ref_secs;
		wait_phase(4);
		run_check(2'd0, now_expected(), clock_pkg::POS_HOUR, "hour_wrap");

		// alarm a few minutes ahead while the clock keeps running
		press(0);
		now_t = now_expected();
		n_inc = int'(now_t.hour);
		repeat (n_inc) press(2);
		alarm_ref = field_inc(alarm_ref, clock_pkg::POS_HOUR, n_inc);
		press(1);
		press(1);
		now_t = now_expected();
		n_inc = int'(now_t.min) + 3;
		repeat (n_inc) press(2);
		alarm_ref = field_inc(alarm_ref, clock_pkg::POS_MIN, n_inc);
		wait_phase(4);
		run_check(2'd0, alarm_ref, clock_pkg::POS_MIN, "alarm_set");
		press(3);
		press(0);

		wait_alarm(1'b1, 5 * 60 * `CLK_PER_SEC);
		if (timeouts == 0 && now_expected() != alarm_ref) begin
			$display("FAIL alarm_hit expected %h actual %h", alarm_ref, now_expected());
			tb_errors++;
		end
		run_check(2'd0, alarm_ref, clock_pkg::POS_MIN, "alarm_hit");
		repeat (3 * `CLK_PER_SEC) @(posedge clk);
		if (!alarm) begin
			$display("o_alarm dropped while the alarm was still enabled");
			tb_errors++;
		end
		press(3);
		wait_alarm(1'b0, 4 * `CLK_PER_SEC);

		$display("errors: checker %0d, testbench %0d, timeouts %0d",
		         chk_errors, tb_errors, timeouts);
		if (chk_errors + tb_errors + timeouts == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== clock.f ====
+incdir+design
design/clock_pkg.sv
design/clock_ctrl_if.sv
design/tick_gen.sv
design/button_ctrl.sv
design/hms_counter.sv
design/timekeeper.sv
design/display_scan.sv
design/clock_top.sv
verif/clock_checker.sv
verif/clock_sva.sv
verif/tb_clock.sv

// ==== run.sh ====
#!/bin/sh
# build and run the digital clock testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_clock \
	-f clock.f -o sim_clock
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/sim_clock > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "all tests passed" sim.log; then
	exit 0
fi
exit 1
